// ==== source/spi_pkg.sv ====
// Shared types, sizes and register map of the APB SPI master
// Every RTL module and the testbench take what they need from here

package spi_pkg;

	// ======================================================================
	// Sizes
	// ======================================================================
	localparam int FIFO_DEPTH = 8;		// Entries in TX and RX FIFO
	localparam int SS_COUNT   = 4;		// Slave select lines
	localparam int DIV_CNT_W  = 3;		// Half period counter, up to 8 PCLK
	localparam int BIT_CNT_W  = 3;		// Bit position within a byte

	typedef logic [9:0]  apb_addr_t;	// Word address, PADDR[11:2]
	typedef logic [31:0] apb_data_t;
	typedef logic [7:0]  spi_byte_t;	// One SPI byte, one FIFO entry

	// ======================================================================
	// Register map, word addresses
	// ======================================================================
	localparam apb_addr_t ADDR_CONFIG  = 10'h000;	// Byte 0x000, RW
	localparam apb_addr_t ADDR_DATA    = 10'h001;	// Byte 0x004, W pushes TX, R pops RX
	localparam apb_addr_t ADDR_STATUS  = 10'h002;	// Byte 0x008, RO
	localparam apb_addr_t ADDR_INTCLR  = 10'h003;	// Byte 0x00C, write 1 to clear
	localparam apb_addr_t ADDR_INTSTAT = 10'h004;	// Byte 0x010, RO

	// CONFIG layout, bit 8 down to bit 0
	typedef struct packed {
		logic                        enable;	// Global enable
		logic                        tx_ie;		// TX empty interrupt enable
		logic                        rx_ie;		// RX done interrupt enable
		logic                        cpol;		// Idle level of SCK
		logic                        cpha;		// 1 = sample on trailing edge
		logic [$clog2(SS_COUNT)-1:0] ss_sel;	// Which ss_n line to drive
		logic [1:0]                  div;		// SCK period = 2 << div PCLK
	} spi_cfg_t;

	typedef struct packed {
		logic busy;
		logic tx_full;
		logic rx_empty;
		logic rx_full;
	} spi_status_t;

	// Same layout for INTSTAT and INTCLR
	typedef struct packed {
		logic rx_done;
		logic tx_empty;
	} spi_irq_t;

	typedef enum logic [1:0] {RESP_IDLE, RESP_WAIT, RESP_ERROR} apb_resp_state_t;
	typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_DONE} spi_state_t;

endpackage

// ==== source/sync_fifo.sv ====
// Synchronous FIFO, used for both the TX and the RX byte queue
// Head entry shows on dout without a pop; a push when full or a pop when empty is dropped

`timescale 1ns/1ps

module sync_fifo #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 8
) (
	input  logic             PCLK,
	input  logic             PRESETn,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout,
	output logic             full,
	output logic             empty
);

	logic [WIDTH-1:0]           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;		// Entries held, 0 to DEPTH
	logic                       do_push;
	logic                       do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full  = (count == ($clog2(DEPTH+1))'(DEPTH));
	assign empty = (count == '0);
	assign dout  = mem[rd_ptr];			// First word fall through

	// Pointers and fill level
	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;	// Push and pop together keep the level
		end
	end

	// Storage
	always_ff @(posedge PCLK)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

endmodule

// ==== source/apb_reg_block.sv ====
// APB slave side of the SPI master: address decode, CONFIG, data window,
// STATUS, sticky interrupts and the PREADY/PSLVERR response machine.
// Good accesses finish with no wait state, bad ones take one wait then an error

`timescale 1ns/1ps

module apb_reg_block import spi_pkg::*;
(
	input  logic        PCLK,
	input  logic        PRESETn,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  apb_addr_t   paddr,
	input  apb_data_t   pwdata,
	output apb_data_t   prdata,
	output logic        pready,
	output logic        pslverr,
	output spi_cfg_t    cfg,
	input  spi_status_t status,
	input  spi_byte_t   rx_data,			// Head of RX FIFO
	output logic        tx_push,
	output spi_byte_t   tx_data,
	output logic        rx_pop,
	input  logic        tx_pop_empty,		// TX FIFO ran dry after a pop
	input  logic        rx_done,			// One byte received
	output spi_irq_t    irq
);

	apb_resp_state_t state;
	apb_resp_state_t state_next;
	spi_cfg_t        cfg_q;
	spi_irq_t        irq_q;
	spi_irq_t        irq_set;
	spi_irq_t        irq_clr;
	logic            bad_access;
	logic            access_ok;
	logic            wr_ok;
	logic            rd_ok;

	// ======================================================================
	// Access decode
	// ======================================================================
	always_comb
	begin
		bad_access = 1'b0;
		if (paddr > ADDR_INTSTAT)
			bad_access = 1'b1;						// Outside the map
		else if (pwrite && (paddr == ADDR_STATUS || paddr == ADDR_INTSTAT))
			bad_access = 1'b1;						// Read only
		else if (!pwrite && paddr == ADDR_DATA && status.rx_empty)
			bad_access = 1'b1;						// Nothing to read
		else if (pwrite && paddr == ADDR_DATA && status.tx_full)
			bad_access = 1'b1;						// No room to write
	end

	// Only a clean access phase in RESP_IDLE touches any state
	assign access_ok = psel && penable && (state == RESP_IDLE) && !bad_access;
	assign wr_ok     = access_ok && pwrite;
	assign rd_ok     = access_ok && !pwrite;

	assign tx_push = wr_ok && (paddr == ADDR_DATA);
	assign tx_data = pwdata[$bits(spi_byte_t)-1:0];
	assign rx_pop  = rd_ok && (paddr == ADDR_DATA);

	// ======================================================================
	// Response FSM
	// ======================================================================
	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
			state <= RESP_IDLE;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		pready     = 1'b1;
		pslverr    = 1'b0;
		case (state)
			RESP_IDLE:
			begin
				if (psel && !penable && bad_access)	// Caught in setup phase
					state_next = RESP_WAIT;
			end
			RESP_WAIT:
			begin
				pready     = 1'b0;					// One wait state
				state_next = RESP_ERROR;
			end
			RESP_ERROR:
			begin
				pslverr    = 1'b1;					// Completes with error
				state_next = RESP_IDLE;
			end
			default: state_next = RESP_IDLE;
		endcase
	end

	// ======================================================================
	// CONFIG and sticky interrupts
	// ======================================================================
	assign irq_set.tx_empty = tx_pop_empty && cfg_q.tx_ie;
	assign irq_set.rx_done  = rx_done && cfg_q.rx_ie;
	assign irq_clr = (wr_ok && paddr == ADDR_INTCLR) ?
		spi_irq_t'(pwdata[$bits(spi_irq_t)-1:0]) : '0;

	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
		begin
			cfg_q <= '0;
			irq_q <= '0;
		end
		else
		begin
			if (wr_ok && paddr == ADDR_CONFIG)
				cfg_q <= spi_cfg_t'(pwdata[$bits(spi_cfg_t)-1:0]);
			irq_q <= spi_irq_t'((irq_q & ~irq_clr) | irq_set);	// New event wins over clear
		end
	end

	assign cfg = cfg_q;
	assign irq = irq_q;

	// Read mux, INTCLR reads as zero
	always_comb
	begin
		prdata = '0;
		case (paddr)
			ADDR_CONFIG:  prdata[$bits(spi_cfg_t)-1:0]    = cfg_q;
			ADDR_DATA:    prdata[$bits(spi_byte_t)-1:0]   = rx_data;
			ADDR_STATUS:  prdata[$bits(spi_status_t)-1:0] = status;
			ADDR_INTSTAT: prdata[$bits(spi_irq_t)-1:0]    = irq_q;
			default:      prdata = '0;
		endcase
	end

endmodule

// ==== source/spi_clock_gen.sv ====
// SCK generator for the SPI master
// Divides PCLK while run is high and flags each SCK edge as leading or trailing;
// with run low SCK rests at cpol

`timescale 1ns/1ps

module spi_clock_gen import spi_pkg::*;
(
	input  logic     PCLK,
	input  logic     PRESETn,
	input  spi_cfg_t cfg,
	input  logic     run,
	output logic     sck,
	output logic     lead_edge,		// SCK leaves its idle level
	output logic     trail_edge		// SCK returns to its idle level
);

	logic [DIV_CNT_W-1:0] cnt;			// PCLK cycles in this half period
	logic [DIV_CNT_W-1:0] half_max;		// Last count of a half period
	logic                 phase;		// 1 while SCK is away from cpol
	logic                 tick;

	// Half period of 1, 2, 4 or 8 PCLK
	assign half_max = DIV_CNT_W'((1 << cfg.div) - 1);
	assign tick     = run && (cnt == half_max);

	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
		begin
			cnt   <= '0;
			phase <= 1'b0;
		end
		else if (!run)
		begin
			cnt   <= '0;				// Park between transfers
			phase <= 1'b0;
		end
		else if (tick)
		begin
			cnt   <= '0;
			phase <= ~phase;			// SCK toggles
		end
		else
			cnt <= cnt + 1'b1;
	end

	assign sck        = cfg.cpol ^ phase;
	assign lead_edge  = tick && !phase;
	assign trail_edge = tick && phase;

endmodule

// ==== source/spi_shift_engine.sv ====
// Transfer engine of the SPI master, 8 bit full duplex, MSB first
// Pops a byte from TX, shifts it out over eight SCK periods while shifting in
// MISO, then pushes the received byte to RX and frees the slave select

`timescale 1ns/1ps

module spi_shift_engine import spi_pkg::*;
(
	input  logic                PCLK,
	input  logic                PRESETn,
	input  spi_cfg_t            cfg,
	input  logic                tx_empty,
	input  logic                rx_full,
	output logic                tx_pop,
	input  spi_byte_t           tx_byte,		// Head of TX FIFO
	output logic                rx_push,
	output spi_byte_t           rx_byte,
	output logic                run,			// Clock generator active
	input  logic                lead_edge,
	input  logic                trail_edge,
	output logic                mosi,
	input  logic                miso,
	output logic [SS_COUNT-1:0] ss_n,
	output logic                busy,
	output logic                rx_done,
	output logic                tx_pop_empty
);

	spi_state_t                  state;
	spi_byte_t                   tx_sr;			// Outgoing bits, MSB on mosi
	spi_byte_t                   rx_sr;			// Incoming bits enter at LSB
	logic [BIT_CNT_W-1:0]        bit_cnt;		// Trailing edges seen
	logic [$clog2(SS_COUNT)-1:0] ss_sel_q;		// Select held for the transfer
	logic                        popped_q;
	logic                        start;
	logic                        sample_edge;
	logic                        shift_edge;
	logic                        last_edge;

	// Back-pressure, no start while RX has no room
	assign start = (state == SPI_IDLE) && cfg.enable && !tx_empty && !rx_full;

	// cpha 0: sample on leading, shift on trailing; cpha 1 the other way round
	assign sample_edge = cfg.cpha ? trail_edge : lead_edge;
	assign shift_edge  = cfg.cpha ? (lead_edge && bit_cnt != '0) : trail_edge;
	assign last_edge   = trail_edge && (bit_cnt == '1);

	// ======================================================================
	// Transfer FSM
	// ======================================================================
	always_ff @(posedge PCLK or negedge PRESETn)
	begin
		if (!PRESETn)
		begin
			state    <= SPI_IDLE;
			bit_cnt  <= '0;
			ss_sel_q <= '0;
			popped_q <= 1'b0;
			tx_sr    <= '0;
		end
		else
		begin
			popped_q <= tx_pop;
			case (state)
				SPI_IDLE:
				begin
					if (start)
					begin
						state    <= SPI_SHIFT;
						bit_cnt  <= '0;
						ss_sel_q <= cfg.ss_sel;
						tx_sr    <= tx_byte;		// Bit 7 ready before first edge
					end
				end
				SPI_SHIFT:
				begin
					if (trail_edge)
						bit_cnt <= bit_cnt + 1'b1;
					if (shift_edge)
						tx_sr <= {tx_sr[6:0], 1'b0};
					if (last_edge)
						state <= SPI_DONE;			// Eighth SCK period over
				end
				SPI_DONE: state <= SPI_IDLE;
				default:  state <= SPI_IDLE;
			endcase
		end
	end

	always_ff @(posedge PCLK)
	begin
		if (run && sample_edge)
			rx_sr <= {rx_sr[6:0], miso};
	end

	// Only the latched slave goes low, and only while shifting
	always_comb
	begin
		ss_n = '1;
		if (state == SPI_SHIFT)
			ss_n[ss_sel_q] = 1'b0;
	end

	assign run          = (state == SPI_SHIFT);
	assign busy         = (state != SPI_IDLE);
	assign mosi         = tx_sr[7];
	assign tx_pop       = start;
	assign rx_push      = (state == SPI_DONE) && !rx_full;
	assign rx_done      = (state == SPI_DONE);
	assign rx_byte      = rx_sr;
	assign tx_pop_empty = popped_q && tx_empty;	// Last queued byte just left

endmodule

// ==== source/apb_spi_top.sv ====
// Top level of the APB SPI master peripheral
// Connects the APB register block, the TX and RX FIFOs, the SCK generator
// and the shift engine; the SPI pins and interrupts leave from here

`timescale 1ns/1ps

module apb_spi_top import spi_pkg::*;
(
	input  logic                PCLK,
	input  logic                PRESETn,
	// APB slave
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  apb_addr_t           paddr,
	input  apb_data_t           pwdata,
	output apb_data_t           prdata,
	output logic                pready,
	output logic                pslverr,
	// SPI master
	output logic                sck,
	output logic                mosi,
	input  logic                miso,
	output logic [SS_COUNT-1:0] ss_n,			// Active low
	// Interrupts
	output logic                tx_int,
	output logic                rx_int,
	output logic                comb_int
);

	spi_cfg_t    cfg;
	spi_status_t status;
	spi_irq_t    irq;
	spi_byte_t   tx_wdata;		// APB to TX FIFO
	spi_byte_t   tx_byte;		// TX FIFO to engine
	spi_byte_t   rx_byte;		// Engine to RX FIFO
	spi_byte_t   rx_data;		// RX FIFO to APB
	logic        tx_push;
	logic        tx_pop;
	logic        tx_full;
	logic        tx_empty;
	logic        rx_push;
	logic        rx_pop;
	logic        rx_full;
	logic        rx_empty;
	logic        busy;
	logic        rx_done;
	logic        tx_pop_empty;
	logic        run;
	logic        lead_edge;
	logic        trail_edge;

	assign status = '{busy: busy, tx_full: tx_full, rx_empty: rx_empty, rx_full: rx_full};

	assign tx_int   = irq.tx_empty;
	assign rx_int   = irq.rx_done;
	assign comb_int = tx_int | rx_int;

	apb_reg_block regs (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.cfg(cfg), .status(status), .rx_data(rx_data),
		.tx_push(tx_push), .tx_data(tx_wdata), .rx_pop(rx_pop),
		.tx_pop_empty(tx_pop_empty), .rx_done(rx_done), .irq(irq)
	);

	sync_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH($bits(spi_byte_t))) tx_fifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(tx_push), .pop(tx_pop), .din(tx_wdata),
		.dout(tx_byte), .full(tx_full), .empty(tx_empty)
	);

	sync_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH($bits(spi_byte_t))) rx_fifo (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.push(rx_push), .pop(rx_pop), .din(rx_byte),
		.dout(rx_data), .full(rx_full), .empty(rx_empty)
	);

	spi_clock_gen clk_gen (
		.PCLK(PCLK), .PRESETn(PRESETn), .cfg(cfg), .run(run),
		.sck(sck), .lead_edge(lead_edge), .trail_edge(trail_edge)
	);

	spi_shift_engine engine (
		.PCLK(PCLK), .PRESETn(PRESETn), .cfg(cfg),
		.tx_empty(tx_empty), .rx_full(rx_full),
		.tx_pop(tx_pop), .tx_byte(tx_byte),
		.rx_push(rx_push), .rx_byte(rx_byte), .run(run),
		.lead_edge(lead_edge), .trail_edge(trail_edge),
		.mosi(mosi), .miso(miso), .ss_n(ss_n),
		.busy(busy), .rx_done(rx_done), .tx_pop_empty(tx_pop_empty)
	);

endmodule

// ==== tests/apb_spi_checker.sv ====
// Protocol assertions for the APB SPI master
// Bound into apb_spi_top; fail_count lets the testbench see a failed assertion

`timescale 1ns/1ps

module apb_spi_checker import spi_pkg::*;
(
	input logic                PCLK,
	input logic                PRESETn,
	input logic [SS_COUNT-1:0] ss_n,
	input logic                sck,
	input spi_cfg_t            cfg,
	input logic                pready,
	input logic                pslverr
);

	int unsigned fail_count = 0;		// Failed assertions so far

	// Never two slaves selected at once
	ss_one_low: assert property (@(posedge PCLK) disable iff (!PRESETn) $onehot0(~ss_n))
		else begin fail_count++; $error("More than one ss_n line is low"); end

	// SCK rests at cpol outside a transfer
	sck_idle_level: assert property (@(posedge PCLK) disable iff (!PRESETn)
		(&ss_n) |-> (sck == cfg.cpol))
		else begin fail_count++; $error("SCK is not at cpol while no slave is selected"); end

	// An error only completes a transfer
	err_with_ready: assert property (@(posedge PCLK) disable iff (!PRESETn) pslverr |-> pready)
		else begin fail_count++; $error("PSLVERR is high while PREADY is low"); end

endmodule

bind apb_spi_top apb_spi_checker spi_checks (
	.PCLK(PCLK), .PRESETn(PRESETn), .ss_n(ss_n), .sck(sck),
	.cfg(cfg), .pready(pready), .pslverr(pslverr)
);

// ==== tests/apb_spi_tb.sv ====
// Testbench for the APB SPI master
// Replays the APB operations of tests/apb_spi_vectors.txt against the DUT,
// with MOSI looped back to MISO so each received byte equals the byte sent

`timescale 1ns/1ps

module apb_spi_tb import spi_pkg::*;
();

	localparam int    HALF_PERIOD     = 5;
	localparam int    RESET_CYCLES    = 5;
	localparam int    SETTLE          = 1;				// Read outputs this long after a falling edge
	localparam int    CYCLES_PER_LINE = 16 * 8 * 4;		// Slowest SCK, one byte, with margin
	localparam string VECTOR_FILE     = "tests/apb_spi_vectors.txt";

	logic                PCLK;
	logic                PRESETn;
	logic                psel;
	logic                penable;
	logic                pwrite;
	apb_addr_t           paddr;
	apb_data_t           pwdata;
	apb_data_t           prdata;
	logic                pready;
	logic                pslverr;
	logic                sck;
	logic                mosi;
	logic                miso;
	logic [SS_COUNT-1:0] ss_n;
	logic                tx_int;
	logic                rx_int;
	logic                comb_int;

	byte         vec_op[$];		// One entry per vector line
	apb_addr_t   vec_addr[$];
	apb_data_t   vec_data[$];
	logic        vec_err[$];
	int          vec_line[$];	// Line number in the file
	spi_byte_t   sent_fill[$];	// Random bytes still to come back
	int          seed        = 32'hd63fb301;
	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 0;

	logic [$clog2(SS_COUNT)-1:0] ss_expect     = '0;	// Slave select field of the last CONFIG
	int unsigned                 ss_low_cycles = 0;		// Cycles with a slave selected
	int unsigned                 ss_low_mark   = 0;		// ss_low_cycles when the last wait ended

	assign miso = mosi;			// Loopback

	apb_spi_top apb_spi_top_inst (
		.PCLK(PCLK), .PRESETn(PRESETn),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.sck(sck), .mosi(mosi), .miso(miso), .ss_n(ss_n),
		.tx_int(tx_int), .rx_int(rx_int), .comb_int(comb_int)
	);

	always #HALF_PERIOD PCLK = ~PCLK;

	// ======================================================================
	// Reporting and compare tasks
	// ======================================================================
	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input apb_data_t got, input apb_data_t want);
		if (got !== want)
			stop_with_error($sformatf("Fail at %0d ns: %s is %08h, expected %08h",
				$time, name, got, want));
	endtask

	task automatic check_resp(input string name, input logic got, input logic want);
		if (got !== want)
			stop_with_error($sformatf("Fail at %0d ns: %s is %b, expected %b",
				$time, name, got, want));
	endtask

	// ======================================================================
	// Bus and wait tasks, each starts and ends on a falling edge
	// ======================================================================
	task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		logic ready;
		psel    = 1'b1;						// Setup phase
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge PCLK);
		penable = 1'b1;						// Access phase, held through wait states
		do
		begin
			#SETTLE;
			ready = pready;
			rdata = prdata;
			err   = pslverr;
			@(negedge PCLK);
		end
		while (!ready);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_for_interrupt();
		while (comb_int !== 1'b1)
			@(negedge PCLK);
	endtask

	// Two matching reads in a row, so the idle cycle between queued bytes does not end the wait
	task automatic poll_until(input apb_addr_t addr, input apb_data_t want, input int ln);
		apb_data_t rdata;
		logic      err;
		int        hits;
		hits = 0;
		while (hits < 2)
		begin
			apb_access(1'b0, addr, '0, rdata, err);
			check_resp($sformatf("pslverr at line %0d", ln), err, 1'b0);
			hits = (rdata === want) ? hits + 1 : 0;
		end
	endtask

	// ======================================================================
	// Vector file
	// ======================================================================
	task automatic load_vectors();
		int          fd;
		int          n;
		int          ln;
		string       line;
		byte         op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] err;
		fd = $fopen(VECTOR_FILE, "r");
		if (fd == 0)
			stop_with_error({"Cannot open the vector file ", VECTOR_FILE});
		ln = 0;
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			ln++;
			if (n == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;						// Blank or comment line
			n = $sscanf(line, "%c %h %h %h", op, addr, data, err);
			if (n != 4)
				stop_with_error($sformatf("Vector line %0d cannot be parsed", ln));
			vec_op.push_back(op);
			vec_addr.push_back(apb_addr_t'(addr >> 2));	// Byte to word address
			vec_data.push_back(data);
			vec_err.push_back(err[0]);
			vec_line.push_back(ln);
		end
		$fclose(fd);
	endtask

	task automatic run_vector(input int i);
		apb_data_t rdata;
		logic      err;
		spi_byte_t fill;
		string     where;
		where = $sformatf("at line %0d", vec_line[i]);
		case (vec_op[i])
			"W":
			begin
				apb_access(1'b1, vec_addr[i], vec_data[i], rdata, err);
				check_resp({"pslverr ", where}, err, vec_err[i]);
				if (!vec_err[i] && vec_addr[i] == ADDR_CONFIG)
					ss_expect = vec_data[i][3:2];	// Slave select index of CONFIG
			end
			"R":
			begin
				apb_access(1'b0, vec_addr[i], '0, rdata, err);
				check_resp({"pslverr ", where}, err, vec_err[i]);
				if (!vec_err[i])
					check_data({"prdata ", where}, rdata, vec_data[i]);
				// Interrupt pins follow INTSTAT, rx done at bit 1 and tx empty at bit 0
				if (!vec_err[i] && vec_addr[i] == ADDR_INTSTAT)
				begin
					check_resp({"rx_int ", where}, rx_int, vec_data[i][1]);
					check_resp({"tx_int ", where}, tx_int, vec_data[i][0]);
					check_resp({"comb_int ", where}, comb_int, |vec_data[i][1:0]);
				end
			end
			"T":
			begin
				fill = spi_byte_t'($random(seed));
				apb_access(1'b1, vec_addr[i], apb_data_t'(fill), rdata, err);
				check_resp({"pslverr ", where}, err, vec_err[i]);
				if (!vec_err[i])
					sent_fill.push_back(fill);	// Comes back through the loopback
			end
			"Q":
			begin
				if (sent_fill.size() == 0)
					stop_with_error({"No random byte is left to read back ", where});
				apb_access(1'b0, vec_addr[i], '0, rdata, err);
				check_resp({"pslverr ", where}, err, vec_err[i]);
				check_data({"prdata ", where}, rdata, apb_data_t'(sent_fill.pop_front()));
			end
			"I": wait_for_interrupt();
			"B":
			begin
				poll_until(vec_addr[i], vec_data[i], vec_line[i]);
				if (ss_low_cycles == ss_low_mark)
					stop_with_error({"No slave select went low before the wait ended ", where});
				ss_low_mark = ss_low_cycles;
			end
			default: stop_with_error({"Unknown opcode in the vector file ", where});
		endcase
	endtask

	// Run limit from the number of vector lines
	always @(posedge PCLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit)
			stop_with_error($sformatf("Timeout, the run did not finish in %0d cycles",
				cycle_count));
	end

	// A transfer lowers only the slave named in CONFIG
	always @(posedge PCLK)
	begin
		logic [SS_COUNT-1:0] ss_want;
		ss_want = ~(SS_COUNT'(1) << ss_expect);
		if (ss_n !== {SS_COUNT{1'b1}})
		begin
			check_data("ss_n", apb_data_t'(ss_n), apb_data_t'(ss_want));
			ss_low_cycles <= ss_low_cycles + 1;
		end
	end

	always @(negedge PCLK)
	begin
		if (apb_spi_top_inst.spi_checks.fail_count != 0)
			stop_with_error("An assertion in the checker failed");
	end

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial
	begin
		PCLK    = 1'b0;
		PRESETn = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		load_vectors();
		cycle_limit = vec_op.size() * CYCLES_PER_LINE;
		repeat (RESET_CYCLES) @(negedge PCLK);
		PRESETn = 1'b1;
		// Pins straight after reset
		check_data("ss_n", apb_data_t'(ss_n), apb_data_t'({SS_COUNT{1'b1}}));
		check_resp("sck", sck, 1'b0);
		check_resp("tx_int", tx_int, 1'b0);
		check_resp("rx_int", rx_int, 1'b0);
		check_resp("comb_int", comb_int, 1'b0);
		check_resp("pready", pready, 1'b1);
		check_resp("pslverr", pslverr, 1'b0);
		for (int i = 0; i < vec_op.size(); i++)
			run_vector(i);
		if (apb_spi_top_inst.spi_checks.fail_count == 0)
		begin
			$display("Verification passed");
			$finish;
		end
		else
			stop_with_error("An assertion in the checker failed");
	end

endmodule

// ==== sim.f ====
source/spi_pkg.sv
source/sync_fifo.sv
source/apb_reg_block.sv
source/spi_clock_gen.sv
source/spi_shift_engine.sv
source/apb_spi_top.sv
tests/apb_spi_checker.sv
tests/apb_spi_tb.sv

// ==== Makefile ====
# Verilator build and run of the APB SPI master testbench
# Any variable can be overridden, e.g. make test OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= apb_spi_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/apb_spi_vectors.txt ====
# Columns: opcode, byte address (hex), data (hex), expected pslverr
# W write, R read and compare, T write random byte, Q read next random byte,
# I wait for comb_int, B poll the address until it reads the data value
# After reset
R 000 00000000 0
R 010 00000000 0
R 008 00000002 0
# One byte per SPI mode, divider 0 and 3, each on its own slave select
W 000 00000100 0
W 004 000000a5 0
B 008 00000000 0
R 004 000000a5 0
W 000 00000117 0
W 004 0000003c 0
B 008 00000000 0
R 004 0000003c 0
W 000 00000128 0
W 004 00000081 0
B 008 00000000 0
R 004 00000081 0
W 000 0000013f 0
W 004 0000007e 0
B 008 00000000 0
R 004 0000007e 0
# Interrupts
W 000 000001c0 0
W 004 0000005e 0
I 000 00000000 0
B 008 00000000 0
R 010 00000003 0
W 00c 00000003 0
R 010 00000000 0
R 004 0000005e 0
# Error responses leave CONFIG alone
R 004 00000000 1
W 008 ffffffff 1
R 014 00000000 1
R 000 000001c0 0
# Full TX FIFO before enable, then RX back-pressure
W 000 00000000 0
W 004 0000005a 0
T 004 00000000 0
T 004 00000000 0
T 004 00000000 0
T 004 00000000 0
T 004 00000000 0
T 004 00000000 0
T 004 00000000 0
W 004 000000ee 1
R 008 00000006 0
W 000 00000100 0
B 008 00000001 0
W 004 0000000f 0
W 004 000000f0 0
R 008 00000001 0
R 004 0000005a 0
Q 004 00000000 0
Q 004 00000000 0
Q 004 00000000 0
Q 004 00000000 0
Q 004 00000000 0
Q 004 00000000 0
Q 004 00000000 0
B 008 00000000 0
R 004 0000000f 0
R 004 000000f0 0
R 008 00000002 0
